/* verilog.f */
+incdir+logic
logic/dcache_pkg.sv
logic/way_ram.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
test/tb_clock.sv
test/mem_model.sv
test/dcache_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = dcache_tb
FLIST = verilog.f

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* test/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic        clk, reset, req_valid, addr_ok, data_ok;
    cpu_req_t    req;
    logic [31:0] rdata;
    logic        rd_req, ret_valid, wr_req, wr_rdy;
    mem_rd_t     rd;
    line_t       ret_data;
    mem_wr_t     wr;
    logic        unc_ren, unc_wen, unc_rvalid, unc_bvalid;
    unc_req_t    unc;
    logic [31:0] unc_rdata;
    logic [31:0] ref_mem [logic [31:0]];
    int          last_lat;

    tb_clock clock_gen (.clk(clk));

    dcache_top uut (
        .clk(clk), .reset(reset), .req_valid_i(req_valid), .req_i(req),
        .addr_ok_o(addr_ok), .data_ok_o(data_ok), .rdata_o(rdata),
        .rd_req_o(rd_req), .rd_o(rd), .ret_valid_i(ret_valid), .ret_data_i(ret_data),
        .wr_req_o(wr_req), .wr_o(wr), .wr_rdy_i(wr_rdy),
        .unc_ren_o(unc_ren), .unc_wen_o(unc_wen), .unc_o(unc),
        .unc_rvalid_i(unc_rvalid), .unc_rdata_i(unc_rdata), .unc_bvalid_i(unc_bvalid)
    );

    mem_model mem (
        .clk(clk), .rd_req_i(rd_req), .rd_i(rd), .ret_valid_o(ret_valid),
        .ret_data_o(ret_data), .wr_req_i(wr_req), .wr_i(wr), .wr_rdy_o(wr_rdy),
        .unc_ren_i(unc_ren), .unc_wen_i(unc_wen), .unc_i(unc),
        .unc_rvalid_o(unc_rvalid), .unc_rdata_o(unc_rdata), .unc_bvalid_o(unc_bvalid)
    );

    task automatic abort_run(input string why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return ref_mem.exists(a) ? ref_mem[a] : a ^ 32'h5a5a5a5a;
    endfunction

    function automatic void ref_update(input logic [31:0] addr, input logic [31:0] wdata,
                                       input logic [3:0] wstrb);
        logic [31:0] word;
        word = ref_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) word[8*b +: 8] = wdata[8*b +: 8];
        end
        ref_mem[{addr[31:2], 2'b00}] = word;
    endfunction

    // entered and left 2 ns after a rising edge
    task automatic issue(input logic op, input logic uncached, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] wstrb,
                         output logic [31:0] data);
        int n;
        n = 0;
        req_valid = 1'b1;
        req = '{op: op, uncached: uncached, wstrb: wstrb, wdata: wdata, addr: addr};
        @(negedge clk);
        while (!addr_ok) begin
            n++;
            if (n > TIMEOUT) abort_run("request was never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #2 req_valid = 1'b0;
        last_lat = 1;  // cycles from acceptance to data_ok
        @(negedge clk);
        while (!data_ok) begin
            last_lat++;
            if (last_lat > TIMEOUT) abort_run("accepted request never completed");
            @(negedge clk);
        end
        data = rdata;
        @(posedge clk);
        #2;
    endtask

    task automatic load_check(input logic uncached, input logic [31:0] addr);
        logic [31:0] data;
        issue(1'b0, uncached, addr, 32'h0, 4'h0, data);
        check("rdata_o", data, ref_word(addr));
    endtask

    task automatic store_word(input logic uncached, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wstrb);
        logic [31:0] ignored;
        ref_update(addr, wdata, wstrb);
        issue(1'b1, uncached, addr, wdata, wstrb, ignored);
    endtask

    task automatic wait_writeback(input int count);
        int n;
        n = 0;
        while (mem.wb_count < count) begin
            n++;
            if (n > TIMEOUT) abort_run("dirty line was never written back");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic read_miss_then_hit();
        load_check(1'b0, 32'h0001_0024);
        load_check(1'b0, 32'h0001_0024);
        check("data_ok_o latency", 32'(last_lat), 32'd1);
        load_check(1'b0, 32'h0001_0038);
        check("data_ok_o latency", 32'(last_lat), 32'd1);
    endtask

    task automatic store_strobes();
        logic [3:0] strobes [4];
        strobes = '{4'b0001, 4'b0110, 4'b1000, 4'b1101};
        load_check(1'b0, 32'h0002_0048);  // bring the line in
        for (int i = 0; i < 4; i++) begin
            store_word(1'b0, 32'h0002_0048, 32'ha5c3_9600 + 32'(i), strobes[i]);
            load_check(1'b0, 32'h0002_0048);
            load_check(1'b0, 32'h0002_004c);  // neighbour word untouched
        end
    endtask

    task automatic store_miss();
        store_word(1'b0, 32'h0003_0064, 32'h1122_3344, 4'b1010);
        load_check(1'b0, 32'h0003_0064);
        load_check(1'b0, 32'h0003_0060);
    endtask

    // three lines in set 5
    task automatic lru_eviction();
        int wb0;
        store_word(1'b0, 32'h0010_00a8, 32'hcafe_f00d, 4'hf);  // line A dirty
        load_check(1'b0, 32'h0020_00a0);                       // line B
        load_check(1'b0, 32'h0010_00a8);                       // A most recent
        wb0 = mem.wb_count;
        load_check(1'b0, 32'h0030_00a4);                       // C replaces clean B
        check("wr_req_o", 32'(wr_req), 32'd0);
        check("writeback count", 32'(mem.wb_count), 32'(wb0));
        load_check(1'b0, 32'h0020_00a0);                       // B replaces dirty A
        wait_writeback(wb0 + 1);
        check("mem_model word", mem.read_word(32'h0010_00a8), ref_word(32'h0010_00a8));
        load_check(1'b0, 32'h0010_00a8);
        load_check(1'b0, 32'h0010_00bc);
    endtask

    task automatic uncached_access();
        store_word(1'b1, 32'h8000_0100, 32'h1234_5678, 4'b0011);
        check("mem_model word", mem.read_word(32'h8000_0100), ref_word(32'h8000_0100));
        load_check(1'b1, 32'h8000_0100);
        load_check(1'b1, 32'h8000_0204);
        load_check(1'b0, 32'h0004_00c0);
        load_check(1'b0, 32'h0001_0024);
    endtask

    // 4 tags over sets 16 to 19
    task automatic random_mix();
        logic [31:0] addr;
        for (int i = 0; i < 200; i++) begin
            addr = {20'h00040 + 20'($urandom_range(3, 0)), 7'd16 + 7'($urandom_range(3, 0)),
                    3'($urandom_range(7, 0)), 2'b00};
            if ($urandom_range(1, 0) == 1) begin
                store_word(1'b0, addr, $urandom(), 4'($urandom_range(15, 0)));
            end else begin
                load_check(1'b0, addr);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h8766cb47));
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        last_lat  = 0;
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        read_miss_then_hit();
        store_strobes();
        store_miss();
        lru_eviction();
        uncached_access();
        random_mix();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* test/mem_model.sv */
`timescale 1ns/100ps

`include "dcache_consts.svh"

module mem_model
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rd_req_i,
    input  mem_rd_t            rd_i,
    output logic               ret_valid_o,
    output line_t              ret_data_o,
    input  logic               wr_req_i,
    input  mem_wr_t            wr_i,
    output logic               wr_rdy_o,
    input  logic               unc_ren_i,
    input  logic               unc_wen_i,
    input  unc_req_t           unc_i,
    output logic               unc_rvalid_o,
    output logic [`DATA_W-1:0] unc_rdata_o,
    output logic               unc_bvalid_o
);

    logic [`DATA_W-1:0] store [logic [`ADDR_W-1:0]];  // only words ever written
    int                 wb_count = 0;

    // untouched words hold their own address xor a fixed pattern
    function automatic logic [`DATA_W-1:0] read_word(input logic [`ADDR_W-1:0] addr);
        logic [`ADDR_W-1:0] a;
        a = {addr[`ADDR_W-1:2], 2'b00};
        return store.exists(a) ? store[a] : a ^ 32'h5a5a5a5a;
    endfunction

    task automatic respond_delay();
        repeat ($urandom_range(6, 1)) @(posedge clk);
        #2;
    endtask

    initial begin
        ret_valid_o = 1'b0;
        ret_data_o  = '0;
        forever begin
            @(negedge clk);
            if (rd_req_i) begin
                respond_delay();
                for (int w = 0; w < `WORDS_PER_LINE; w++) begin
                    ret_data_o[w] = read_word({rd_i.addr[`ADDR_W-1:`OFFSET_W], 3'(w), 2'b00});
                end
                ret_valid_o = 1'b1;
                @(posedge clk);
                #2 ret_valid_o = 1'b0;
            end
        end
    end

    initial begin
        wr_rdy_o = 1'b0;
        forever begin
            @(negedge clk);
            if (wr_req_i) begin
                respond_delay();
                for (int w = 0; w < `WORDS_PER_LINE; w++) begin
                    store[{wr_i.addr[`ADDR_W-1:`OFFSET_W], 3'(w), 2'b00}] = wr_i.data[w];
                end
                wb_count++;
                wr_rdy_o = 1'b1;  // line lands in the same cycle it is accepted
                @(posedge clk);
                #2 wr_rdy_o = 1'b0;
            end
        end
    end

    // a strobe that disagrees with the op field gets no answer
    initial begin
        logic [`DATA_W-1:0] word;
        unc_rvalid_o = 1'b0;
        unc_bvalid_o = 1'b0;
        unc_rdata_o  = '0;
        forever begin
            @(negedge clk);
            if (unc_ren_i || unc_wen_i) begin
                respond_delay();
                if (unc_wen_i && unc_i.op) begin
                    word = read_word(unc_i.addr);
                    for (int b = 0; b < 4; b++) begin
                        if (unc_i.wstrb[b]) word[8*b +: 8] = unc_i.wdata[8*b +: 8];
                    end
                    store[{unc_i.addr[`ADDR_W-1:2], 2'b00}] = word;
                    unc_bvalid_o = 1'b1;
                end else if (unc_ren_i && !unc_i.op) begin
                    unc_rdata_o  = read_word(unc_i.addr);
                    unc_rvalid_o = 1'b1;
                end
                @(posedge clk);
                #2;
                unc_rvalid_o = 1'b0;
                unc_bvalid_o = 1'b0;
            end
        end
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/100ps

`include "dcache_consts.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid_i,
    input  cpu_req_t           req_i,
    output logic               addr_ok_o,
    output logic               data_ok_o,
    output logic [`DATA_W-1:0] rdata_o,
    output logic               rd_req_o,
    output mem_rd_t            rd_o,
    input  logic               ret_valid_i,
    input  line_t              ret_data_i,
    output logic               wr_req_o,
    output mem_wr_t            wr_o,
    input  logic               wr_rdy_i,
    output logic               unc_ren_o,
    output logic               unc_wen_o,
    output unc_req_t           unc_o,
    input  logic               unc_rvalid_i,
    input  logic [`DATA_W-1:0] unc_rdata_i,
    input  logic               unc_bvalid_i
);

    tagv_t               tag_rdata [2];
    line_t               data_rdata [2];
    logic [`INDEX_W-1:0] ram_raddr;
    logic [`INDEX_W-1:0] ram_waddr;
    logic                tag_we [2];
    logic                data_we [2];
    tagv_t               tag_wdata;
    line_t               data_wdata;

    dcache_ctrl ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .addr_ok_o    (addr_ok_o),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .tag_rdata_i  (tag_rdata),
        .data_rdata_i (data_rdata),
        .ram_raddr_o  (ram_raddr),
        .tag_we_o     (tag_we),
        .data_we_o    (data_we),
        .ram_waddr_o  (ram_waddr),
        .tag_wdata_o  (tag_wdata),
        .data_wdata_o (data_wdata),
        .rd_req_o     (rd_req_o),
        .rd_o         (rd_o),
        .ret_valid_i  (ret_valid_i),
        .ret_data_i   (ret_data_i),
        .wr_req_o     (wr_req_o),
        .wr_o         (wr_o),
        .wr_rdy_i     (wr_rdy_i),
        .unc_ren_o    (unc_ren_o),
        .unc_wen_o    (unc_wen_o),
        .unc_o        (unc_o),
        .unc_rvalid_i (unc_rvalid_i),
        .unc_rdata_i  (unc_rdata_i),
        .unc_bvalid_i (unc_bvalid_i)
    );

    way_ram #(.payload_t(line_t)) data_way0 (
        .clk(clk), .reset(reset), .raddr_i(ram_raddr), .rdata_o(data_rdata[0]),
        .we_i(data_we[0]), .waddr_i(ram_waddr), .wdata_i(data_wdata)
    );

    way_ram #(.payload_t(line_t)) data_way1 (
        .clk(clk), .reset(reset), .raddr_i(ram_raddr), .rdata_o(data_rdata[1]),
        .we_i(data_we[1]), .waddr_i(ram_waddr), .wdata_i(data_wdata)
    );

    way_ram #(.payload_t(tagv_t)) tag_way0 (
        .clk(clk), .reset(reset), .raddr_i(ram_raddr), .rdata_o(tag_rdata[0]),
        .we_i(tag_we[0]), .waddr_i(ram_waddr), .wdata_i(tag_wdata)
    );

    way_ram #(.payload_t(tagv_t)) tag_way1 (
        .clk(clk), .reset(reset), .raddr_i(ram_raddr), .rdata_o(tag_rdata[1]),
        .we_i(tag_we[1]), .waddr_i(ram_waddr), .wdata_i(tag_wdata)
    );

endmodule

/* logic/dcache_ctrl.sv */
`timescale 1ns/100ps

`include "dcache_consts.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid_i,
    input  cpu_req_t            req_i,
    output logic                addr_ok_o,
    output logic                data_ok_o,
    output logic [`DATA_W-1:0]  rdata_o,
    input  tagv_t               tag_rdata_i [2],
    input  line_t               data_rdata_i [2],
    output logic [`INDEX_W-1:0] ram_raddr_o,
    output logic                tag_we_o [2],
    output logic                data_we_o [2],
    output logic [`INDEX_W-1:0] ram_waddr_o,
    output tagv_t               tag_wdata_o,
    output line_t              data_wdata_o,
    output logic                rd_req_o,
    output mem_rd_t             rd_o,
    input  logic                ret_valid_i,
    input  line_t               ret_data_i,
    output logic                wr_req_o,
    output mem_wr_t             wr_o,
    input  logic                wr_rdy_i,
    output logic                unc_ren_o,
    output logic                unc_wen_o,
    output unc_req_t            unc_o,
    input  logic                unc_rvalid_i,
    input  logic [`DATA_W-1:0]  unc_rdata_i,
    input  logic                unc_bvalid_i
);

    typedef enum logic [4:0] {
        S_IDLE   = 5'b00001,  // also the lookup stage
        S_MISS   = 5'b00010,
        S_REFILL = 5'b00100,
        S_UNC    = 5'b01000,
        S_CLEAR  = 5'b10000
    } state_t;

    state_t state, state_n;

    cpu_req_t            req_q;
    logic                req_v;
    logic [`INDEX_W-1:0] idx;
    logic [`INDEX_W-1:0] clr_idx;
    logic [`SET_NUM-1:0] lru;          // points at the next victim
    logic [`SET_NUM-1:0] dirty [2];
    logic [1:0]          hit_w;
    logic                hit_way, victim, vic_dirty;
    logic                accept, lkp, lkp_hit, lkp_miss, lkp_unc, store_hit;
    logic                collide, refill_we, cap_now, wb_acc;
    logic                wb_pend, miss_hold, unc_done;
    logic [`DATA_W-1:0]  resp_q;
    line_t               merge_src;
    logic [1:0]          outstanding;

    function automatic line_t merge_store(line_t line, logic [2:0] sel,
                                          logic [`DATA_W-1:0] wdata, logic [3:0] wstrb);
        line_t res;
        res = line;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                res[sel][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign idx      = req_q.addr[`INDEX_LOC];
    assign victim   = lru[idx];
    assign hit_way  = hit_w[1];

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign hit_w[w] = tag_rdata_i[w].valid && tag_rdata_i[w].tag == req_q.addr[`TAG_LOC];
        assign tag_we_o[w]  = (state == S_CLEAR) || (refill_we && victim == 1'(w));
        assign data_we_o[w] = (store_hit && hit_w[w]) || (refill_we && victim == 1'(w));
    end

    assign lkp       = (state == S_IDLE) && req_v;
    assign lkp_unc   = lkp && req_q.uncached;
    assign lkp_hit   = lkp && !req_q.uncached && (|hit_w);
    assign lkp_miss  = lkp && !req_q.uncached && !(|hit_w);
    assign store_hit = lkp_hit && req_q.op;
    assign refill_we = (state == S_MISS) && ret_valid_i;
    assign vic_dirty = dirty[victim][idx] && tag_rdata_i[victim].valid;

    // next access to the line being stored waits a cycle
    assign collide   = store_hit && req_valid_i
                       && req_i.addr[`ADDR_W-1:`OFFSET_W] == req_q.addr[`ADDR_W-1:`OFFSET_W];
    assign addr_ok_o = (state == S_IDLE) && !(lkp && !lkp_hit) && !collide;
    assign accept    = req_valid_i && addr_ok_o;

    assign ram_raddr_o = accept ? req_i.addr[`INDEX_LOC] : idx;
    assign ram_waddr_o = (state == S_CLEAR) ? clr_idx : idx;
    assign tag_wdata_o = (state == S_CLEAR) ? '0 : {1'b1, req_q.addr[`TAG_LOC]};

    assign merge_src    = (state == S_MISS) ? ret_data_i : data_rdata_i[hit_way];
    assign data_wdata_o = req_q.op ? merge_store(merge_src, req_q.addr[`WORD_LOC],
                                                 req_q.wdata, req_q.wstrb)
                                   : merge_src;

    assign data_ok_o = lkp_hit || (state == S_REFILL) || ((state == S_UNC) && unc_done);
    assign rdata_o   = lkp_hit ? data_rdata_i[hit_way][req_q.addr[`WORD_LOC]] : resp_q;

    always_comb begin
        state_n = state;
        unique case (state)
            S_CLEAR:  if (clr_idx == `INDEX_W'(`SET_NUM - 1)) state_n = S_IDLE;
            S_IDLE: begin
                if (lkp_unc) begin
                    state_n = S_UNC;
                end else if (lkp_miss) begin
                    state_n = S_MISS;
                end
            end
            S_MISS:   if (refill_we) state_n = S_REFILL;
            S_REFILL: state_n = S_IDLE;
            S_UNC:    if (unc_done) state_n = S_IDLE;
            default:  state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_CLEAR;
            clr_idx <= '0;
        end else begin
            state <= state_n;
            if (state == S_CLEAR) begin
                clr_idx <= clr_idx + 1'b1;  // tag sweep
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_v <= 1'b0;
        end else if (accept) begin
            req_v <= 1'b1;
        end else if (data_ok_o) begin
            req_v <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru      <= '0;
            dirty[0] <= '0;
            dirty[1] <= '0;
        end else begin
            if (lkp_hit) begin
                lru[idx] <= ~hit_way;
            end
            if (store_hit) begin
                dirty[hit_way][idx] <= 1'b1;
            end
            if (refill_we) begin
                lru[idx]           <= ~victim;
                dirty[victim][idx] <= req_q.op;
            end
        end
    end

    // an older writeback still in flight defers capture and the line read
    assign wb_acc  = wb_pend && wr_rdy_i;
    assign cap_now = (lkp_miss && !(wb_pend && !wr_rdy_i))
                     || ((state == S_MISS) && miss_hold && wr_rdy_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_pend   <= 1'b0;
            miss_hold <= 1'b0;
        end else begin
            if (cap_now) begin
                wb_pend <= vic_dirty;
            end else if (wb_acc) begin
                wb_pend <= 1'b0;
            end
            if (lkp_miss) begin
                miss_hold <= wb_pend && !wr_rdy_i;
            end else if (wr_rdy_i) begin
                miss_hold <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cap_now) begin
            wr_o.addr <= {tag_rdata_i[victim].tag, idx, `OFFSET_W'(0)};
            wr_o.data <= data_rdata_i[victim];
        end
    end

    assign wr_req_o = wb_pend;
    assign rd_req_o = (state == S_MISS) && !miss_hold;
    assign rd_o     = '{addr: {req_q.addr[`ADDR_W-1:`OFFSET_W], `OFFSET_W'(0)}};

    always_ff @(posedge clk) begin
        if (reset) begin
            unc_done <= 1'b0;
        end else if (state == S_UNC) begin
            unc_done <= !unc_done && (unc_rvalid_i || unc_bvalid_i);
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            resp_q <= ret_data_i[req_q.addr[`WORD_LOC]];
        end else if ((state == S_UNC) && unc_rvalid_i) begin
            resp_q <= unc_rdata_i;
        end
    end

    assign unc_ren_o = (state == S_UNC) && !unc_done && !req_q.op;
    assign unc_wen_o = (state == S_UNC) && !unc_done && req_q.op;
    assign unc_o     = '{op: req_q.op, addr: req_q.addr, wdata: req_q.wdata,
                         wstrb: req_q.wstrb};

    // requests accepted and not yet answered
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 2'(accept) - 2'(data_ok_o);
        end
    end

    a_rd_unc_excl: assert property (@(posedge clk) disable iff (reset)
        !(rd_req_o && (unc_ren_o || unc_wen_o)))
        else $error("line read and uncached strobe together");

    a_ret_in_read: assert property (@(posedge clk) disable iff (reset)
        ret_valid_i |-> rd_req_o)
        else $error("ret_valid without a line read");

    a_one_data_ok: assert property (@(posedge clk) disable iff (reset)
        data_ok_o |-> outstanding != 2'd0)
        else $error("data_ok without an outstanding request");

endmodule

/* logic/way_ram.sv */
`timescale 1ns/100ps

`include "dcache_consts.svh"

module way_ram #(
    parameter type payload_t = logic [31:0]
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [`INDEX_W-1:0] raddr_i,
    output payload_t            rdata_o,
    input  logic                we_i,
    input  logic [`INDEX_W-1:0] waddr_i,
    input  payload_t            wdata_i
);

    payload_t mem [`SET_NUM];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read during write of the same index sees the old entry
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= mem[raddr_i];
        end
    end

    a_we_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(we_i))
        else $error("way_ram write enable unknown");

endmodule

/* logic/dcache_pkg.sv */
`include "dcache_consts.svh"

package dcache_pkg;

    typedef struct packed {
        logic               op;        // 1 = store
        logic               uncached;
        logic [3:0]         wstrb;
        logic [`DATA_W-1:0] wdata;
        logic [`ADDR_W-1:0] addr;
    } cpu_req_t;

    // word 0 sits in the low bits
    typedef logic [`WORDS_PER_LINE-1:0][`DATA_W-1:0] line_t;

    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
    } tagv_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;  // line aligned
    } mem_rd_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        line_t              data;
    } mem_wr_t;

    typedef struct packed {
        logic               op;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
        logic [3:0]         wstrb;
    } unc_req_t;

endpackage

/* logic/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`define ADDR_W         32
`define DATA_W         32

`define TAG_W          20
`define INDEX_W        7
`define OFFSET_W       5

`define WORDS_PER_LINE 8
`define SET_NUM        128

// physical address fields
`define TAG_LOC        31:12
`define INDEX_LOC      11:5
`define WORD_LOC       4:2

`endif
